//--- hw/axi_fifo_pkg.sv
////////////////////////////////////////
// axi fifo slave shared definitions
// slot map, bus widths, burst types
// and the address request bundle
////////////////////////////////////////
`default_nettype none

package axi_fifo_pkg;

    // bus widths
    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;
    localparam int ID_W   = 4;
    localparam int LEN_W  = 8;

    // one 32-bit word per slot
    localparam int BYTES_PER_SLOT = 4;
    localparam int SLOT_LSB       = $clog2(BYTES_PER_SLOT);

    // slots 0..3 read, 4..7 write
    localparam int RD_SLOTS = 4;
    localparam int WR_SLOTS = 4;

    // wide enough to see slots past the map
    localparam int SLOT_W = 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ID_W-1:0]   id_t;
    // beats minus one
    typedef logic [LEN_W-1:0]  len_t;
    typedef logic [SLOT_W-1:0] slot_idx_t;

    // byte address of slot 0
    localparam addr_t BASE_ADDR = 32'h8000_0000;

    // AXI burst encoding, 2'b11 is reserved
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } burst_t;

    // AR or AW request
    typedef struct packed {
        addr_t  addr;
        len_t   len;
        burst_t burst;
        id_t    id;
    } ax_req_t;

    typedef enum logic {
        RD_IDLE,
        RD_BURST
    } rd_state_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DATA,
        WR_RESP
    } wr_state_t;

endpackage

`default_nettype wire

//--- hw/burst_addr_gen.sv
////////////////////////////////////////
// burst address generator
// holds one AXI burst and walks its
// slot index one beat at a time
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module burst_addr_gen
    import axi_fifo_pkg::*;
(
    input  logic      s_axi_mem,
    input  logic      arst_n,
    input  logic      load,
    input  ax_req_t   req,
    input  logic      step,
    output slot_idx_t slot,
    output id_t       id,
    output logic      last
);

    len_t      len_q;
    len_t      cnt_q;
    burst_t    burst_q;
    addr_t     offset;
    slot_idx_t start_slot;
    slot_idx_t wrap_mask;
    slot_idx_t next_slot;

    // start slot relative to slot 0
    assign offset     = req.addr - BASE_ADDR;
    assign start_slot = slot_idx_t'(offset >> SLOT_LSB);

    // wrap window is len+1 slots, so len itself is the mask
    assign wrap_mask = slot_idx_t'(len_q);

    always_comb begin
        case (burst_q)
            FIXED: next_slot = slot;
            INCR:  next_slot = slot + 1'b1;
            WRAP:  next_slot = (slot & ~wrap_mask) | ((slot + 1'b1) & wrap_mask);
            default: next_slot = slot;
        endcase
    end

    always_ff @(posedge s_axi_mem or negedge arst_n) begin
        if (!arst_n) begin
            slot    <= '0;
            id      <= '0;
            len_q   <= '0;
            cnt_q   <= '0;
            burst_q <= FIXED;
        end else if (load) begin
            slot    <= start_slot;
            id      <= req.id;
            len_q   <= req.len;
            cnt_q   <= '0;
            burst_q <= req.burst;
        end else if (step) begin
            slot  <= next_slot;
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign last = (cnt_q == len_q);

    // the channel must stop stepping after the last beat
    assert property (@(posedge s_axi_mem) disable iff (!arst_n)
        step && !load |-> cnt_q <= len_q)
        else $error("burst_addr_gen: step past end of burst");

endmodule

`default_nettype wire

//--- hw/fifo_read_channel.sv
////////////////////////////////////////
// AXI read channel
// maps AR/R bursts onto the source
// stream slots with one word per beat
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fifo_read_channel
    import axi_fifo_pkg::*;
(
    input  logic                     s_axi_mem,
    input  logic                     arst_n,
    // AR
    input  ax_req_t                  ar_req,
    input  logic                     arvalid,
    output logic                     arready,
    // R
    output data_t                    rdata,
    output id_t                      rid,
    output logic                     rlast,
    output logic                     rvalid,
    input  logic                     rready,
    // source slots
    input  data_t [RD_SLOTS-1:0]     src_data,
    input  logic  [RD_SLOTS-1:0]     src_valid,
    output logic  [RD_SLOTS-1:0]     src_ready
);

    rd_state_t state;
    logic      ar_hs;
    logic      r_hs;
    slot_idx_t slot;
    logic      last;

    assign arready = (state == RD_IDLE);
    assign ar_hs   = arvalid & arready;
    assign r_hs    = rvalid & rready;

    burst_addr_gen rd_gen_inst (
        .s_axi_mem (s_axi_mem),
        .arst_n    (arst_n),
        .load      (ar_hs),
        .req       (ar_req),
        .step      (r_hs),
        .slot      (slot),
        .id        (rid),
        .last      (last)
    );

    always_ff @(posedge s_axi_mem or negedge arst_n) begin
        if (!arst_n) begin
            state <= RD_IDLE;
        end else begin
            case (state)
                RD_IDLE:  if (ar_hs) state <= RD_BURST;
                RD_BURST: if (r_hs && rlast) state <= RD_IDLE;
                default:  state <= RD_IDLE;
            endcase
        end
    end

    // unmapped slots answer at once with zero
    always_comb begin
        rvalid    = 1'b0;
        rdata     = '0;
        src_ready = '0;
        if (state == RD_BURST) begin
            rvalid = 1'b1;
            for (int i = 0; i < RD_SLOTS; i++) begin
                if (slot == slot_idx_t'(i)) begin
                    rvalid       = src_valid[i];
                    rdata        = src_data[i];
                    src_ready[i] = src_valid[i] & rready;
                end
            end
        end
    end

    assign rlast = rvalid & last;

    // a stalled beat keeps its word until the master takes it
    assert property (@(posedge s_axi_mem) disable iff (!arst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rlast))
        else $error("fifo_read_channel: beat changed under back-pressure");

    assert property (@(posedge s_axi_mem) disable iff (!arst_n)
        $onehot0(src_ready))
        else $error("fifo_read_channel: more than one source popped");

endmodule

`default_nettype wire

//--- hw/fifo_write_channel.sv
////////////////////////////////////////
// AXI write channel
// maps AW/W bursts onto the sink
// stream slots and returns B
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fifo_write_channel
    import axi_fifo_pkg::*;
(
    input  logic                     s_axi_mem,
    input  logic                     arst_n,
    // AW
    input  ax_req_t                  aw_req,
    input  logic                     awvalid,
    output logic                     awready,
    // W
    input  data_t                    wdata,
    input  logic                     wlast,
    input  logic                     wvalid,
    output logic                     wready,
    // B
    output id_t                      bid,
    output logic                     bvalid,
    input  logic                     bready,
    // sink slots
    output data_t [WR_SLOTS-1:0]     snk_data,
    output logic  [WR_SLOTS-1:0]     snk_valid,
    input  logic  [WR_SLOTS-1:0]     snk_ready
);

    wr_state_t state;
    logic      aw_hs;
    logic      w_hs;
    logic      b_hs;
    slot_idx_t slot;
    logic      last;

    assign awready = (state == WR_IDLE);
    assign bvalid  = (state == WR_RESP);
    assign aw_hs   = awvalid & awready;
    assign w_hs    = wvalid & wready;
    assign b_hs    = bvalid & bready;

    burst_addr_gen wr_gen_inst (
        .s_axi_mem (s_axi_mem),
        .arst_n    (arst_n),
        .load      (aw_hs),
        .req       (aw_req),
        .step      (w_hs),
        .slot      (slot),
        .id        (bid),
        .last      (last)
    );

    always_ff @(posedge s_axi_mem or negedge arst_n) begin
        if (!arst_n) begin
            state <= WR_IDLE;
        end else begin
            case (state)
                WR_IDLE: if (aw_hs) state <= WR_DATA;
                WR_DATA: if (w_hs && wlast) state <= WR_RESP;
                WR_RESP: if (b_hs) state <= WR_IDLE;
                default: state <= WR_IDLE;
            endcase
        end
    end

    // sink i sits at slot RD_SLOTS+i
    // any other slot swallows the beat
    always_comb begin
        wready    = 1'b0;
        snk_data  = '0;
        snk_valid = '0;
        if (state == WR_DATA) begin
            wready = 1'b1;
            for (int i = 0; i < WR_SLOTS; i++) begin
                if (slot == slot_idx_t'(RD_SLOTS + i)) begin
                    wready       = snk_ready[i];
                    snk_data[i]  = wdata;
                    snk_valid[i] = wvalid & snk_ready[i];
                end
            end
        end
    end

    // master's wlast must match the burst length from AW
    assert property (@(posedge s_axi_mem) disable iff (!arst_n)
        w_hs |-> wlast == last)
        else $error("fifo_write_channel: wlast disagrees with awlen");

    assert property (@(posedge s_axi_mem) disable iff (!arst_n)
        $onehot0(snk_valid))
        else $error("fifo_write_channel: more than one sink pushed");

endmodule

`default_nettype wire

//--- hw/axi_fifo_slave.sv
////////////////////////////////////////
// AXI4 slave over stream ports
// read channel feeds from sources,
// write channel drives the sinks
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module axi_fifo_slave
    import axi_fifo_pkg::*;
(
    input  logic                     s_axi_mem,
    input  logic                     arst_n,
    // AR
    input  ax_req_t                  ar_req,
    input  logic                     arvalid,
    output logic                     arready,
    // R
    output data_t                    rdata,
    output id_t                      rid,
    output logic                     rlast,
    output logic                     rvalid,
    input  logic                     rready,
    // AW
    input  ax_req_t                  aw_req,
    input  logic                     awvalid,
    output logic                     awready,
    // W
    input  data_t                    wdata,
    input  logic                     wlast,
    input  logic                     wvalid,
    output logic                     wready,
    // B
    output id_t                      bid,
    output logic                     bvalid,
    input  logic                     bready,
    // stream slots
    input  data_t [RD_SLOTS-1:0]     src_data,
    input  logic  [RD_SLOTS-1:0]     src_valid,
    output logic  [RD_SLOTS-1:0]     src_ready,
    output data_t [WR_SLOTS-1:0]     snk_data,
    output logic  [WR_SLOTS-1:0]     snk_valid,
    input  logic  [WR_SLOTS-1:0]     snk_ready
);

    fifo_read_channel rd_chan_inst (
        .s_axi_mem (s_axi_mem),
        .arst_n    (arst_n),
        .ar_req    (ar_req),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rid       (rid),
        .rlast     (rlast),
        .rvalid    (rvalid),
        .rready    (rready),
        .src_data  (src_data),
        .src_valid (src_valid),
        .src_ready (src_ready)
    );

    fifo_write_channel wr_chan_inst (
        .s_axi_mem (s_axi_mem),
        .arst_n    (arst_n),
        .aw_req    (aw_req),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wlast     (wlast),
        .wvalid    (wvalid),
        .wready    (wready),
        .bid       (bid),
        .bvalid    (bvalid),
        .bready    (bready),
        .snk_data  (snk_data),
        .snk_valid (snk_valid),
        .snk_ready (snk_ready)
    );

endmodule

`default_nettype wire

//--- tests/axi_fifo_slave_tb.sv
////////////////////////////////////////
// testbench for axi_fifo_slave
// random stream models on all slots,
// reference slot walk per burst beat
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module axi_fifo_slave_tb
    import axi_fifo_pkg::*;
;
    localparam int TIMEOUT = 200;

    logic                 s_axi_mem;
    logic                 arst_n;
    ax_req_t              ar_req;
    logic                 arvalid;
    logic                 arready;
    data_t                rdata;
    id_t                  rid;
    logic                 rlast;
    logic                 rvalid;
    logic                 rready;
    ax_req_t              aw_req;
    logic                 awvalid;
    logic                 awready;
    data_t                wdata;
    logic                 wlast;
    logic                 wvalid;
    logic                 wready;
    id_t                  bid;
    logic                 bvalid;
    logic                 bready;
    data_t [RD_SLOTS-1:0] src_data;
    logic  [RD_SLOTS-1:0] src_valid;
    logic  [RD_SLOTS-1:0] src_ready;
    data_t [WR_SLOTS-1:0] snk_data;
    logic  [WR_SLOTS-1:0] snk_valid;
    logic  [WR_SLOTS-1:0] snk_ready;

    logic [31:0]          lfsr;
    int                   src_cnt [RD_SLOTS];
    logic  [RD_SLOTS-1:0] src_pop = '0;
    int                   exp_cnt [RD_SLOTS] = '{default: 0};
    ax_req_t              rd_req;
    ax_req_t              wr_req;
    int                   rd_beat = 0;
    int                   wr_beat = 0;
    data_t                snk_words [$];
    int                   snk_slots [$];
    int                   errors = 0;
    int                   checks = 0;

    axi_fifo_slave axi_fifo_slave_inst (.*);

    initial begin
        s_axi_mem = 1'b0;
        forever #20 s_axi_mem = ~s_axi_mem;
    end

    // 32-bit Fibonacci LFSR, taps 32 22 2 1
    function automatic logic take_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    // expected slot of a beat, straight from the AXI burst rules
    function automatic int expected_slot(input ax_req_t req, input int beat);
        int start;
        int n;
        int base;
        start = int'((req.addr - BASE_ADDR) >> SLOT_LSB);
        n     = int'(req.len) + 1;
        base  = start - (start % n);
        case (req.burst)
            INCR:    expected_slot = start + beat;
            WRAP:    expected_slot = base + (start - base + beat) % n;
            default: expected_slot = start;
        endcase
    endfunction

    function automatic ax_req_t make_req(input int slot, input int beats,
                                         input burst_t burst, input id_t id);
        ax_req_t req;
        req.addr  = BASE_ADDR + addr_t'(slot * BYTES_PER_SLOT);
        req.len   = len_t'(beats - 1);
        req.burst = burst;
        req.id    = id;
        return req;
    endfunction

    // write data pattern, tagged with id and beat
    function automatic data_t beat_word(input ax_req_t req, input int beat);
        return {16'hc0de, 4'h0, req.id, 8'(beat)};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s is 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout: no %s within %0d cycles at %0t", what, TIMEOUT, $time);
    endtask

    // source words carry the slot number in the top byte
    always_comb begin
        for (int i = 0; i < RD_SLOTS; i++) begin
            src_data[i] = {8'(i), 24'(src_cnt[i])};
        end
    end

    // sources hold valid until popped, sinks and rready toggle freely
    initial begin : stream_models
        lfsr      = 32'hf283ea28;
        src_valid = '0;
        snk_ready = '0;
        rready    = 1'b0;
        for (int i = 0; i < RD_SLOTS; i++) begin
            src_cnt[i] = 0;
        end
        forever begin
            @(posedge s_axi_mem);
            #1;
            for (int i = 0; i < RD_SLOTS; i++) begin
                if (src_pop[i]) src_cnt[i] = src_cnt[i] + 1;
                if (!src_valid[i] || src_pop[i]) src_valid[i] = take_bit();
            end
            for (int i = 0; i < WR_SLOTS; i++) begin
                snk_ready[i] = take_bit();
            end
            rready = take_bit();
        end
    end

    // outputs are stable at the falling edge, transfers land on the next rise
    always @(negedge s_axi_mem) begin : compare_beats
        int                  si;
        data_t               exp_data;
        logic [WR_SLOTS-1:0] exp_valid;
        src_pop = src_valid & src_ready;
        if (arst_n) begin
            if (arvalid && arready) begin
                rd_req  = ar_req;
                rd_beat = 0;
            end
            if (awvalid && awready) begin
                wr_req  = aw_req;
                wr_beat = 0;
            end
            if (rvalid && rready) begin
                si       = expected_slot(rd_req, rd_beat);
                exp_data = '0;
                if (si < RD_SLOTS) begin
                    exp_data    = {8'(si), 24'(exp_cnt[si])};
                    exp_cnt[si] = exp_cnt[si] + 1;
                end
                check_value("rdata", rdata, exp_data);
                check_value("rid", 32'(rid), 32'(rd_req.id));
                check_value("rlast", 32'(rlast), 32'(rd_beat == int'(rd_req.len)));
                rd_beat++;
            end
            if (wvalid && wready) begin
                si        = expected_slot(wr_req, wr_beat);
                exp_valid = '0;
                if (si >= RD_SLOTS && si < RD_SLOTS + WR_SLOTS) begin
                    exp_valid[si - RD_SLOTS] = 1'b1;
                end
                check_value("snk_valid", 32'(snk_valid), 32'(exp_valid));
                wr_beat++;
            end
            for (int i = 0; i < WR_SLOTS; i++) begin
                if (snk_valid[i]) begin
                    snk_words.push_back(snk_data[i]);
                    snk_slots.push_back(i);
                end
            end
        end
    end

    task automatic do_read(input ax_req_t req);
        int t;
        @(posedge s_axi_mem);
        #1;
        ar_req  = req;
        arvalid = 1'b1;
        t = 0;
        do begin
            @(negedge s_axi_mem);
            t++;
        end while (!arready && t < TIMEOUT);
        if (!arready) report_timeout("arready");
        @(posedge s_axi_mem);
        #1;
        arvalid = 1'b0;
        t = 0;
        do begin
            @(posedge s_axi_mem);
            t++;
        end while (rd_beat <= int'(req.len) && t < TIMEOUT);
        if (rd_beat <= int'(req.len)) report_timeout("read beats");
    endtask

    task automatic do_write(input ax_req_t req);
        int t;
        @(posedge s_axi_mem);
        #1;
        aw_req  = req;
        awvalid = 1'b1;
        t = 0;
        do begin
            @(negedge s_axi_mem);
            t++;
        end while (!awready && t < TIMEOUT);
        if (!awready) report_timeout("awready");
        @(posedge s_axi_mem);
        #1;
        awvalid = 1'b0;
        for (int k = 0; k <= int'(req.len); k++) begin
            wdata  = beat_word(req, k);
            wlast  = (k == int'(req.len));
            wvalid = 1'b1;
            t = 0;
            do begin
                @(negedge s_axi_mem);
                t++;
            end while (!wready && t < TIMEOUT);
            if (!wready) report_timeout("wready");
            @(posedge s_axi_mem);
            #1;
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
        // hold off the response, bvalid must stay and AW stay closed
        repeat (3) begin
            @(negedge s_axi_mem);
            check_value("bvalid", 32'(bvalid), 32'd1);
            check_value("awready", 32'(awready), 32'd0);
        end
        @(posedge s_axi_mem);
        #1;
        bready = 1'b1;
        t = 0;
        do begin
            @(negedge s_axi_mem);
            t++;
        end while (!bvalid && t < TIMEOUT);
        if (!bvalid) report_timeout("bvalid");
        check_value("bid", 32'(bid), 32'(req.id));
        @(posedge s_axi_mem);
        #1;
        bready = 1'b0;
        @(negedge s_axi_mem);
        check_value("awready", 32'(awready), 32'd1);
    endtask

    initial begin : main
        ax_req_t req;
        int      n0;
        int      si;
        int      saved_cnt [RD_SLOTS];
        arst_n  = 1'b0;
        ar_req  = '0;
        arvalid = 1'b0;
        aw_req  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wlast   = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        repeat (8) @(posedge s_axi_mem);
        #1;
        arst_n = 1'b1;

        @(negedge s_axi_mem);
        check_value("arready", 32'(arready), 32'd1);
        check_value("awready", 32'(awready), 32'd1);
        check_value("rvalid", 32'(rvalid), 32'd0);
        check_value("bvalid", 32'(bvalid), 32'd0);
        check_value("snk_valid", 32'(snk_valid), 32'd0);

        do_read(make_req(0, 4, INCR, 4'h3));
        do_read(make_req(2, 5, FIXED, 4'h5));
        do_read(make_req(1, 4, WRAP, 4'h9));

        // four sinks, one word each, in slot order
        n0  = snk_words.size();
        req = make_req(4, 4, INCR, 4'h6);
        do_write(req);
        check_value("sink word count", 32'(snk_words.size() - n0), 32'd4);
        for (int k = 0; k < 4; k++) begin
            if (n0 + k < snk_words.size()) begin
                si = expected_slot(req, k);
                check_value("sink slot", 32'(snk_slots[n0 + k]), 32'(si - RD_SLOTS));
                check_value("snk_data", snk_words[n0 + k], beat_word(req, k));
            end
        end

        // slot 12 is past the map on both sides
        for (int i = 0; i < RD_SLOTS; i++) begin
            saved_cnt[i] = src_cnt[i];
        end
        do_read(make_req(12, 4, INCR, 4'ha));
        for (int i = 0; i < RD_SLOTS; i++) begin
            check_value("source count", 32'(src_cnt[i]), 32'(saved_cnt[i]));
        end
        n0 = snk_words.size();
        do_write(make_req(12, 2, INCR, 4'hc));
        check_value("sink word count", 32'(snk_words.size()), 32'(n0));

        repeat (2) @(posedge s_axi_mem);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- axi_fifo_slave.f
hw/axi_fifo_pkg.sv
hw/burst_addr_gen.sv
hw/fifo_read_channel.sv
hw/fifo_write_channel.sv
hw/axi_fifo_slave.sv
tests/axi_fifo_slave_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the axi_fifo_slave testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f axi_fifo_slave.f \
    --top-module axi_fifo_slave_tb \
    -Mdir "$BUILD_DIR" -o axi_fifo_slave_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/axi_fifo_slave_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$LOG"; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation passed"
exit 0
